//--- include/qcore_settings.svh
`ifndef QCORE_SETTINGS_SVH
`define QCORE_SETTINGS_SVH

// Core widths, fixed for the whole design

// Program memory, 256 words
`define QCORE_PMEM_AW 8
// Data memory, 64 words
`define QCORE_DMEM_AW 6
// Register bank, 16 entries
`define QCORE_REG_AW 4
`define QCORE_DATA_W 32
// Immediate, sign-extended wherever used
`define QCORE_IMM_W 16
`define QCORE_PORT_AW 4
// Full instruction word
`define QCORE_INSTR_W 40

`endif

//--- src/qcore_pkg.sv
`include "qcore_settings.svh"

package qcore_pkg;

   typedef enum logic [2:0] {
      OP_NOP     = 3'd0,
      OP_REG_WR  = 3'd1,
      OP_MEM_WR  = 3'd2,
      OP_MEM_RD  = 3'd3,
      OP_BRANCH  = 3'd4,
      OP_PORT_WR = 3'd5
   } opcode_e;

   typedef enum logic [2:0] {
      C_ALWAYS = 3'd0,
      C_EQ     = 3'd1,   // Z
      C_LT     = 3'd2,   // S
      C_NZ     = 3'd3,
      C_NS     = 3'd4,
      C_FLAG   = 3'd5,   // External flag high
      C_NFLAG  = 3'd6,
      C_NEVER  = 3'd7
   } cond_e;

   typedef enum logic [2:0] {
      ADD    = 3'd0,
      SUB    = 3'd1,
      AND    = 3'd2,
      OR     = 3'd3,
      XOR    = 3'd4,
      SHL    = 3'd5,
      SHR    = 3'd6,   // Logical
      PASS_B = 3'd7
   } alu_op_e;

   // Instruction word, MSB first
   typedef struct packed {
      opcode_e                    opcode;
      cond_e                      cond;
      alu_op_e                    alu_op;
      logic [`QCORE_REG_AW-1:0]   rd;
      logic [`QCORE_REG_AW-1:0]   rs_a;
      logic [`QCORE_REG_AW-1:0]   rs_b;
      logic                       imm_sel;   // Operand B from immediate
      logic                       flag_we;
      logic [`QCORE_IMM_W-1:0]    imm;
      logic                       pad;
   } instr_t;

   typedef struct packed {
      logic                       valid;
      opcode_e                    opcode;
      cond_e                      cond;
      alu_op_e                    alu_op;
      logic                       flag_we;
      logic                       imm_sel;
      logic [`QCORE_REG_AW-1:0]   rd;
      logic [`QCORE_DATA_W-1:0]   op_a;      // R[rs_a]
      logic [`QCORE_DATA_W-1:0]   op_b;      // R[rs_b]
      logic [`QCORE_DATA_W-1:0]   imm;
   } id_ex_t;

   typedef struct packed {
      logic                       valid;     // Condition already applied
      opcode_e                    opcode;
      logic                       reg_we;
      logic [`QCORE_REG_AW-1:0]   rd;
      logic [`QCORE_DATA_W-1:0]   result;
      logic [`QCORE_DMEM_AW-1:0]  dmem_addr;
      logic [`QCORE_DATA_W-1:0]   st_dt;
      logic [`QCORE_PORT_AW-1:0]  port_addr;
      logic [`QCORE_DATA_W-1:0]   port_dt;
   } ex_wb_t;

   typedef struct packed {
      logic                       we;
      logic [`QCORE_REG_AW-1:0]   addr;
      logic [`QCORE_DATA_W-1:0]   data;
   } reg_wr_t;

   typedef struct packed {
      logic [`QCORE_PORT_AW-1:0]  addr;
      logic [`QCORE_DATA_W-1:0]   data;
   } port_t;

endpackage

//--- src/qcore_fetch.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_fetch (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        hold_i,
   input  logic                        redirect_i,
   input  logic [`QCORE_PMEM_AW-1:0]   target_i,
   output logic [`QCORE_PMEM_AW-1:0]   pmem_addr_o,
   output logic                        pmem_en_o,
   input  qcore_pkg::instr_t           pmem_dt_i,
   output qcore_pkg::instr_t           instr_o,
   output logic                        instr_valid_o
);

   logic [`QCORE_PMEM_AW-1:0]  pc_q;
   logic                       pend_q;   // Read issued last cycle

   // Memory output register doubles as the fetch/decode register
   assign pmem_addr_o   = pc_q;
   assign pmem_en_o     = ~hold_i;
   assign instr_o       = pmem_dt_i;
   assign instr_valid_o = pend_q & ~redirect_i;   // Word behind a taken branch

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pc_q   <= '0;
         pend_q <= 1'b0;
      end else if (redirect_i) begin
         pc_q   <= target_i;
         // Read issued this cycle is on the wrong path
         pend_q <= 1'b0;
      end else if (!hold_i) begin
         pc_q   <= pc_q + 1'b1;
         pend_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks

   // Redirect only comes while fetch is free to move
   a_redirect_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
      redirect_i |-> !hold_i);

endmodule

//--- src/qcore_decode.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_decode (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  qcore_pkg::instr_t           instr_i,
   input  logic                        instr_valid_i,
   input  logic                        wb_stall_i,
   input  logic                        redirect_i,
   input  qcore_pkg::ex_wb_t           ex_wb_i,
   output logic [`QCORE_REG_AW-1:0]    rs_a_o,
   output logic [`QCORE_REG_AW-1:0]    rs_b_o,
   input  logic [`QCORE_DATA_W-1:0]    rs_a_dt_i,
   input  logic [`QCORE_DATA_W-1:0]    rs_b_dt_i,
   output logic                        hazard_o,
   output qcore_pkg::id_ex_t           id_ex_o
);
   import qcore_pkg::*;

   logic    use_a, use_b;
   logic    ex_busy, wb_busy;
   logic    clash_a, clash_b;
   id_ex_t  id_ex_d, id_ex_q;

   assign rs_a_o = instr_i.rs_a;
   assign rs_b_o = instr_i.rs_b;

   // Sources each opcode really reads
   always_comb begin
      use_a = 1'b0;
      use_b = 1'b0;
      case (instr_i.opcode)
         OP_REG_WR: begin
            use_a = 1'b1;
            use_b = ~instr_i.imm_sel;
         end
         OP_MEM_WR: begin
            use_a = 1'b1;   // Address base
            use_b = 1'b1;   // Store data
         end
         OP_MEM_RD, OP_PORT_WR: use_a = 1'b1;
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Read-after-write interlock

   // Execute writers count before their condition is known
   assign ex_busy = id_ex_q.valid && (id_ex_q.opcode inside {OP_REG_WR, OP_MEM_RD});
   assign wb_busy = ex_wb_i.valid && ex_wb_i.reg_we;

   assign clash_a = use_a && (instr_i.rs_a != '0) &&
                    ((ex_busy && (id_ex_q.rd == instr_i.rs_a)) ||
                     (wb_busy && (ex_wb_i.rd == instr_i.rs_a)));
   assign clash_b = use_b && (instr_i.rs_b != '0) &&
                    ((ex_busy && (id_ex_q.rd == instr_i.rs_b)) ||
                     (wb_busy && (ex_wb_i.rd == instr_i.rs_b)));

   assign hazard_o = instr_valid_i && (clash_a || clash_b);

   always_comb begin
      id_ex_d.valid   = instr_valid_i & ~hazard_o & ~redirect_i;   // Bubble otherwise
      id_ex_d.opcode  = instr_i.opcode;
      id_ex_d.cond    = instr_i.cond;
      id_ex_d.alu_op  = instr_i.alu_op;
      id_ex_d.flag_we = instr_i.flag_we;
      id_ex_d.imm_sel = instr_i.imm_sel;
      id_ex_d.rd      = instr_i.rd;
      id_ex_d.op_a    = rs_a_dt_i;
      id_ex_d.op_b    = rs_b_dt_i;
      id_ex_d.imm     = {{(`QCORE_DATA_W-`QCORE_IMM_W){instr_i.imm[`QCORE_IMM_W-1]}},
                         instr_i.imm};
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         id_ex_q.valid <= 1'b0;
      end else if (!wb_stall_i) begin
         id_ex_q <= id_ex_d;
      end
   end

   assign id_ex_o = id_ex_q;

   // Stalled or squashed slot reaches execute empty
   a_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!wb_stall_i && (hazard_o || redirect_i)) |=> !id_ex_o.valid);

endmodule

//--- src/qcore_reg_bank.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_reg_bank (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic [`QCORE_REG_AW-1:0]    rs_a_i,
   input  logic [`QCORE_REG_AW-1:0]    rs_b_i,
   output logic [`QCORE_DATA_W-1:0]    rs_a_dt_o,
   output logic [`QCORE_DATA_W-1:0]    rs_b_dt_o,
   input  qcore_pkg::reg_wr_t          wr_i
);

   logic [`QCORE_DATA_W-1:0] regs_q [2**`QCORE_REG_AW];

   //////////////////////////////////////////////////////////////////////
   // Write port

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         for (int i = 0; i < 2**`QCORE_REG_AW; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_i.we && (wr_i.addr != '0)) begin   // R0 ignores writes
         regs_q[wr_i.addr] <= wr_i.data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read ports

   // Asynchronous, a write shows up the cycle after it lands
   assign rs_a_dt_o = (rs_a_i == '0) ? '0 : regs_q[rs_a_i];
   assign rs_b_dt_o = (rs_b_i == '0) ? '0 : regs_q[rs_b_i];

endmodule

//--- src/qcore_execute.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_execute (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        flag_i,
   input  logic                        wb_stall_i,
   input  qcore_pkg::id_ex_t           id_ex_i,
   output logic                        redirect_o,
   output logic [`QCORE_PMEM_AW-1:0]   target_o,
   output qcore_pkg::ex_wb_t           ex_wb_o
);
   import qcore_pkg::*;

   logic                       z_q, s_q;   // Zero and sign flags
   logic                       cond_ok, exec;
   logic [`QCORE_DATA_W-1:0]   alu_b, alu_res, addr_sum;
   ex_wb_t                     ex_wb_d, ex_wb_q;

   // Condition check
   always_comb begin
      case (id_ex_i.cond)
         C_ALWAYS: cond_ok = 1'b1;
         C_EQ:     cond_ok = z_q;
         C_LT:     cond_ok = s_q;
         C_NZ:     cond_ok = ~z_q;
         C_NS:     cond_ok = ~s_q;
         C_FLAG:   cond_ok = flag_i;
         C_NFLAG:  cond_ok = ~flag_i;
         default:  cond_ok = 1'b0;   // C_NEVER
      endcase
   end

   assign exec = id_ex_i.valid & cond_ok;

   //////////////////////////////////////////////////////////////////////
   // ALU

   assign alu_b = id_ex_i.imm_sel ? id_ex_i.imm : id_ex_i.op_b;

   always_comb begin
      case (id_ex_i.alu_op)
         ADD:     alu_res = id_ex_i.op_a + alu_b;
         SUB:     alu_res = id_ex_i.op_a - alu_b;
         AND:     alu_res = id_ex_i.op_a & alu_b;
         OR:      alu_res = id_ex_i.op_a | alu_b;
         XOR:     alu_res = id_ex_i.op_a ^ alu_b;
         SHL:     alu_res = id_ex_i.op_a << alu_b[4:0];
         SHR:     alu_res = id_ex_i.op_a >> alu_b[4:0];
         default: alu_res = alu_b;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         z_q <= 1'b0;
         s_q <= 1'b0;
      end else if (exec && id_ex_i.flag_we && !wb_stall_i) begin
         z_q <= (alu_res == '0);
         s_q <= alu_res[`QCORE_DATA_W-1];
      end
   end

   // Data memory address, base plus offset
   assign addr_sum = id_ex_i.op_a + id_ex_i.imm;

   assign redirect_o = exec && (id_ex_i.opcode == OP_BRANCH) && !wb_stall_i;
   assign target_o   = id_ex_i.imm[`QCORE_PMEM_AW-1:0];

   always_comb begin
      ex_wb_d.valid     = exec;
      ex_wb_d.opcode    = id_ex_i.opcode;
      ex_wb_d.reg_we    = exec && (id_ex_i.opcode inside {OP_REG_WR, OP_MEM_RD}) &&
                          (id_ex_i.rd != '0);
      ex_wb_d.rd        = id_ex_i.rd;
      ex_wb_d.result    = alu_res;
      ex_wb_d.dmem_addr = addr_sum[`QCORE_DMEM_AW-1:0];
      ex_wb_d.st_dt     = id_ex_i.op_b;
      ex_wb_d.port_addr = id_ex_i.rd;     // Port address rides in rd
      ex_wb_d.port_dt   = id_ex_i.op_a;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ex_wb_q.valid <= 1'b0;
      end else if (!wb_stall_i) begin
         ex_wb_q <= ex_wb_d;
      end
   end

   assign ex_wb_o = ex_wb_q;

   // Taken branch leaves an empty slot behind it
   a_redirect_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      redirect_o |-> (id_ex_i.opcode == OP_BRANCH) ##1 !id_ex_i.valid);

endmodule

//--- src/qcore_mem_wb.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_mem_wb (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  qcore_pkg::ex_wb_t     ex_wb_i,
   input  logic                  port_ready_i,
   output logic                  port_valid_o,
   output qcore_pkg::port_t      port_o,
   output logic                  wb_stall_o,
   output qcore_pkg::reg_wr_t    reg_wr_o
);
   import qcore_pkg::*;

   logic [`QCORE_DATA_W-1:0]  dmem [2**`QCORE_DMEM_AW];
   logic [`QCORE_DATA_W-1:0]  ld_dt;
   logic                      st_en;

   //////////////////////////////////////////////////////////////////////
   // Output port

   // Payload is held in ex_wb until the transfer
   assign port_valid_o = ex_wb_i.valid && (ex_wb_i.opcode == OP_PORT_WR);
   assign port_o.addr  = ex_wb_i.port_addr;
   assign port_o.data  = ex_wb_i.port_dt;

   assign wb_stall_o = port_valid_o && !port_ready_i;   // Freezes the whole pipe

   //////////////////////////////////////////////////////////////////////
   // Data memory

   assign st_en = ex_wb_i.valid && (ex_wb_i.opcode == OP_MEM_WR) && !wb_stall_o;

   // No stores while the pipe is in reset
   always_ff @(posedge clk_i) begin
      if (rst_ni && st_en) begin
         dmem[ex_wb_i.dmem_addr] <= ex_wb_i.st_dt;
      end
   end

   assign ld_dt = dmem[ex_wb_i.dmem_addr];

   // Writeback
   assign reg_wr_o.we   = ex_wb_i.valid && ex_wb_i.reg_we && !wb_stall_o;
   assign reg_wr_o.addr = ex_wb_i.rd;
   assign reg_wr_o.data = (ex_wb_i.opcode == OP_MEM_RD) ? ld_dt : ex_wb_i.result;

   // Port word frozen while the sink is not ready
   a_port_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (port_valid_o && !port_ready_i) |=> (port_valid_o && $stable(port_o)));

endmodule

//--- src/qcore_cpu.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module qcore_cpu (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        flag_i,
   output logic [`QCORE_PMEM_AW-1:0]   pmem_addr_o,
   output logic                        pmem_en_o,
   input  logic [`QCORE_INSTR_W-1:0]   pmem_dt_i,
   output logic                        port_valid_o,
   input  logic                        port_ready_i,
   output qcore_pkg::port_t            port_o
);
   import qcore_pkg::*;

   instr_t                     instr;
   logic                       instr_valid;
   logic                       hazard, wb_stall;
   logic                       hold;
   logic                       redirect;
   logic [`QCORE_PMEM_AW-1:0]  target;
   logic [`QCORE_REG_AW-1:0]   rs_a, rs_b;
   logic [`QCORE_DATA_W-1:0]   rs_a_dt, rs_b_dt;
   id_ex_t                     id_ex;
   ex_wb_t                     ex_wb;
   reg_wr_t                    reg_wr;

   // Fetch stops on an interlock or port back-pressure
   assign hold = hazard | wb_stall;

   //////////////////////////////////////////////////////////////////////
   // Stages

   qcore_fetch u_fetch (
      .clk_i         ( clk_i        ),
      .rst_ni        ( rst_ni       ),
      .hold_i        ( hold         ),
      .redirect_i    ( redirect     ),
      .target_i      ( target       ),
      .pmem_addr_o   ( pmem_addr_o  ),
      .pmem_en_o     ( pmem_en_o    ),
      .pmem_dt_i     ( pmem_dt_i    ),
      .instr_o       ( instr        ),
      .instr_valid_o ( instr_valid  )
   );

   qcore_decode u_decode (
      .clk_i         ( clk_i        ),
      .rst_ni        ( rst_ni       ),
      .instr_i       ( instr        ),
      .instr_valid_i ( instr_valid  ),
      .wb_stall_i    ( wb_stall     ),
      .redirect_i    ( redirect     ),
      .ex_wb_i       ( ex_wb        ),
      .rs_a_o        ( rs_a         ),
      .rs_b_o        ( rs_b         ),
      .rs_a_dt_i     ( rs_a_dt      ),
      .rs_b_dt_i     ( rs_b_dt      ),
      .hazard_o      ( hazard       ),
      .id_ex_o       ( id_ex        )
   );

   qcore_reg_bank u_reg_bank (
      .clk_i         ( clk_i        ),
      .rst_ni        ( rst_ni       ),
      .rs_a_i        ( rs_a         ),
      .rs_b_i        ( rs_b         ),
      .rs_a_dt_o     ( rs_a_dt      ),
      .rs_b_dt_o     ( rs_b_dt      ),
      .wr_i          ( reg_wr       )
   );

   qcore_execute u_execute (
      .clk_i         ( clk_i        ),
      .rst_ni        ( rst_ni       ),
      .flag_i        ( flag_i       ),
      .wb_stall_i    ( wb_stall     ),
      .id_ex_i       ( id_ex        ),
      .redirect_o    ( redirect     ),
      .target_o      ( target       ),
      .ex_wb_o       ( ex_wb        )
   );

   qcore_mem_wb u_mem_wb (
      .clk_i         ( clk_i        ),
      .rst_ni        ( rst_ni       ),
      .ex_wb_i       ( ex_wb        ),
      .port_ready_i  ( port_ready_i ),
      .port_valid_o  ( port_valid_o ),
      .port_o        ( port_o       ),
      .wb_stall_o    ( wb_stall     ),
      .reg_wr_o      ( reg_wr       )
   );

endmodule

//--- sim/tb_qcore.sv
`timescale 1ns/1ps
`include "qcore_settings.svh"

module tb_qcore;
   import qcore_pkg::*;

   localparam int CYCLE_LIMIT    = 6000;   // 6 tests x 250 cycles x 4
   localparam int PER_TEST_LIMIT = 1000;

   logic                          clk_i  = 1'b0;
   logic                          rst_ni = 1'b0;
   logic                          flag;
   logic [`QCORE_PMEM_AW-1:0]     pmem_addr;
   logic                          pmem_en;
   logic [`QCORE_INSTR_W-1:0]     pmem_dt;
   logic                          port_valid;
   logic                          port_ready;
   port_t                         port_word;

   instr_t       prog [2**`QCORE_PMEM_AW];
   instr_t       pmem_word;
   port_t        exp_q [$];
   port_t        got_q [$];
   int           wp;
   int           errors = 0;
   int           tests_run = 0;
   int           tests_bad = 0;
   int           err_mark;
   int           cycle_cnt = 0;
   int           stall_cnt = 0;
   string        cur_name;
   logic         bp_en = 1'b0;
   logic [31:0]  rng;
   logic         held = 1'b0;
   port_t        held_word;

   qcore_cpu uut (
      .clk_i        ( clk_i      ),
      .rst_ni       ( rst_ni     ),
      .flag_i       ( flag       ),
      .pmem_addr_o  ( pmem_addr  ),
      .pmem_en_o    ( pmem_en    ),
      .pmem_dt_i    ( pmem_dt    ),
      .port_valid_o ( port_valid ),
      .port_ready_i ( port_ready ),
      .port_o       ( port_word  )
   );

   always #4 clk_i = ~clk_i;

   // Program memory, word shows up one cycle after the enabled read
   always @(posedge clk_i) begin
      if (pmem_en) begin
         pmem_word = prog[pmem_addr];
         #1 pmem_dt = pmem_word;
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles before the tests were done", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Port collector, sampled mid-cycle where port signals are settled

   always @(negedge clk_i) begin
      if (!rst_ni) begin
         held = 1'b0;
      end else begin
         if (held) begin   // Word was refused last cycle
            check_value("port_valid_o", 1, port_valid);
            check_value("port_o", held_word, port_word);
         end
         if (port_valid && port_ready) begin
            got_q.push_back(port_word);
         end
         held      = port_valid && !port_ready;
         held_word = port_word;
         if (held) begin
            stall_cnt++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act) begin
         $display("error: time %0t, %s: expected %0h, got %0h", $time, name, exp, act);
         errors++;
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] sext(input int imm);
      return {{16{imm[15]}}, imm[15:0]};
   endfunction

   function automatic instr_t assemble(opcode_e op, cond_e c, alu_op_e a, int rd, int ra,
                                       int rb, bit isel, bit fwe, int imm);
      instr_t w;
      w.opcode  = op;
      w.cond    = c;
      w.alu_op  = a;
      w.rd      = rd[3:0];
      w.rs_a    = ra[3:0];
      w.rs_b    = rb[3:0];
      w.imm_sel = isel;
      w.flag_we = fwe;
      w.imm     = imm[15:0];
      w.pad     = 1'b0;
      return w;
   endfunction

   task automatic place(opcode_e op, cond_e c, alu_op_e a, int rd, int ra, int rb,
                        bit isel, bit fwe, int imm);
      prog[wp] = assemble(op, c, a, rd, ra, rb, isel, fwe, imm);
      wp++;
   endtask

   // Branch to itself, the core idles here
   task automatic end_program();
      place(OP_BRANCH, C_ALWAYS, ADD, 0, 0, 0, 0, 0, wp);
   endtask

   task automatic new_program();
      for (int i = 0; i < 2**`QCORE_PMEM_AW; i++) begin
         prog[i] = '0;
      end
      wp = 0;
      exp_q.delete();
   endtask

   task automatic expect_word(input int addr, input logic [31:0] data);
      port_t w;
      w.addr = addr[3:0];
      w.data = data;
      exp_q.push_back(w);
   endtask

   task automatic tick();
      @(posedge clk_i);
      #1;
   endtask

   task automatic step_cycle();
      tick();
      if (bp_en) begin
         rng        = xorshift32(rng);
         port_ready = rng[4];
      end
   endtask

   task automatic reset_core();
      rst_ni = 1'b0;
      repeat (2) step_cycle();
      got_q.delete();
      rst_ni = 1'b1;
   endtask

   task automatic run_and_compare();
      int n;
      reset_core();
      n = 0;
      while (got_q.size() < exp_q.size() && n < PER_TEST_LIMIT) begin
         step_cycle();
         n++;
      end
      if (got_q.size() < exp_q.size()) begin
         $display("%s: port stream stopped at %0d of %0d words after %0d cycles",
                  cur_name, got_q.size(), exp_q.size(), n);
         errors++;
      end
      repeat (20) step_cycle();   // Room for stray extra words
      check_value("port word count", exp_q.size(), got_q.size());
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
         check_value($sformatf("port_o word %0d", i), exp_q[i], got_q[i]);
      end
   endtask

   task automatic begin_test(input string name);
      cur_name = name;
      err_mark = errors;
      tests_run++;
   endtask

   task automatic finish_test();
      if (errors == err_mark) begin
         $display("%s: ok", cur_name);
      end else begin
         $display("%s: %0d errors", cur_name, errors - err_mark);
         tests_bad++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests

   task automatic alu_chain();
      logic [31:0] v [10];
      begin_test("alu_chain");
      new_program();
      place(OP_REG_WR, C_ALWAYS, ADD,    1, 0, 0, 1, 0, 'h7ff0);
      place(OP_REG_WR, C_ALWAYS, ADD,    2, 1, 0, 1, 0, 'hffff);
      place(OP_REG_WR, C_ALWAYS, SUB,    3, 2, 1, 0, 0, 0);
      place(OP_REG_WR, C_ALWAYS, AND,    4, 3, 0, 1, 0, 'h0f0f);
      place(OP_REG_WR, C_ALWAYS, OR,     5, 4, 1, 0, 0, 0);
      place(OP_REG_WR, C_ALWAYS, XOR,    6, 5, 0, 1, 0, 'h8001);
      place(OP_REG_WR, C_ALWAYS, SHL,    7, 6, 0, 1, 0, 4);
      place(OP_REG_WR, C_ALWAYS, SHR,    8, 7, 0, 1, 0, 8);
      place(OP_REG_WR, C_ALWAYS, PASS_B, 9, 0, 8, 0, 0, 0);
      place(OP_REG_WR, C_ALWAYS, ADD,    0, 9, 0, 1, 0, 1);   // Lost in R0
      for (int k = 0; k < 10; k++) begin
         place(OP_PORT_WR, C_ALWAYS, ADD, k, k, 0, 0, 0, 0);
      end
      end_program();
      v[0] = '0;
      v[1] = sext('h7ff0);
      v[2] = v[1] + sext('hffff);
      v[3] = v[2] - v[1];
      v[4] = v[3] & sext('h0f0f);
      v[5] = v[4] | v[1];
      v[6] = v[5] ^ sext('h8001);
      v[7] = v[6] << 4;
      v[8] = v[7] >> 8;
      v[9] = v[8];
      for (int k = 0; k < 10; k++) begin
         expect_word(k, v[k]);
      end
      run_and_compare();
      finish_test();
   endtask

   // Countdown loop followed by conditional port writes
   task automatic load_countdown();
      new_program();
      place(OP_REG_WR,  C_ALWAYS, ADD, 1,  0, 0, 1, 0, 3);
      place(OP_REG_WR,  C_ALWAYS, ADD, 2,  0, 0, 1, 0, 'h55);
      place(OP_REG_WR,  C_ALWAYS, SUB, 1,  1, 0, 1, 1, 1);   // Loop top at 2
      place(OP_PORT_WR, C_ALWAYS, ADD, 2,  1, 0, 0, 0, 0);
      place(OP_BRANCH,  C_NZ,     ADD, 0,  0, 0, 0, 0, 2);
      place(OP_PORT_WR, C_ALWAYS, ADD, 15, 1, 0, 0, 0, 0);
      place(OP_PORT_WR, C_EQ,     ADD, 3,  2, 0, 0, 0, 0);
      place(OP_PORT_WR, C_LT,     ADD, 4,  2, 0, 0, 0, 0);
      place(OP_PORT_WR, C_NS,     ADD, 5,  2, 0, 0, 0, 0);
      place(OP_REG_WR,  C_ALWAYS, SUB, 3,  0, 0, 1, 1, 1);
      place(OP_PORT_WR, C_LT,     ADD, 6,  3, 0, 0, 0, 0);
      place(OP_PORT_WR, C_EQ,     ADD, 7,  3, 0, 0, 0, 0);
      place(OP_PORT_WR, C_NEVER,  ADD, 8,  3, 0, 0, 0, 0);
      place(OP_PORT_WR, C_NZ,     ADD, 9,  2, 0, 0, 0, 0);
      place(OP_BRANCH,  C_ALWAYS, ADD, 0,  0, 0, 0, 0, 17);
      place(OP_PORT_WR, C_ALWAYS, ADD, 10, 2, 0, 0, 0, 0);   // Wrong path
      place(OP_PORT_WR, C_ALWAYS, ADD, 11, 2, 0, 0, 0, 0);
      place(OP_PORT_WR, C_ALWAYS, ADD, 12, 3, 0, 0, 0, 0);
      end_program();
      for (int k = 2; k >= 0; k--) begin
         expect_word(2, k);
      end
      expect_word(15, 0);
      expect_word(3, 'h55);   // Z set, S clear
      expect_word(5, 'h55);
      expect_word(6, 32'hffff_ffff);
      expect_word(9, 'h55);
      expect_word(12, 32'hffff_ffff);
   endtask

   task automatic flag_conditions();
      begin_test("flag_conditions");
      load_countdown();
      run_and_compare();
      finish_test();
   endtask

   task automatic external_flag();
      begin_test("external_flag");
      for (int f = 1; f >= 0; f--) begin
         new_program();
         place(OP_REG_WR,  C_ALWAYS, ADD, 1, 0, 0, 1, 0, 'h11);
         place(OP_REG_WR,  C_ALWAYS, ADD, 2, 0, 0, 1, 0, 'h22);
         place(OP_BRANCH,  C_FLAG,   ADD, 0, 0, 0, 0, 0, 5);
         place(OP_PORT_WR, C_ALWAYS, ADD, 1, 1, 0, 0, 0, 0);
         place(OP_PORT_WR, C_ALWAYS, ADD, 4, 2, 0, 0, 0, 0);
         place(OP_PORT_WR, C_NFLAG,  ADD, 2, 2, 0, 0, 0, 0);
         place(OP_PORT_WR, C_ALWAYS, ADD, 3, 1, 0, 0, 0, 0);
         end_program();
         if (f == 0) begin
            expect_word(1, 'h11);
            expect_word(4, 'h22);
            expect_word(2, 'h22);
         end
         expect_word(3, 'h11);
         flag = f[0];
         run_and_compare();
      end
      flag = 1'b0;
      finish_test();
   endtask

   task automatic data_memory();
      begin_test("data_memory");
      new_program();
      place(OP_REG_WR,  C_ALWAYS, ADD, 1, 0, 0, 1, 0, 5);   // Base address
      place(OP_REG_WR,  C_ALWAYS, ADD, 2, 0, 0, 1, 0, 'h7abc);
      place(OP_REG_WR,  C_ALWAYS, ADD, 3, 0, 0, 1, 0, 'h1357);
      place(OP_REG_WR,  C_ALWAYS, ADD, 4, 0, 0, 1, 0, 'h9bdf);
      place(OP_MEM_WR,  C_ALWAYS, ADD, 0, 1, 2, 0, 0, 3);
      place(OP_MEM_WR,  C_ALWAYS, ADD, 0, 1, 3, 0, 0, 'h3c);   // 65 wraps to 1
      place(OP_MEM_WR,  C_ALWAYS, ADD, 0, 1, 4, 0, 0, 'hffff);
      place(OP_MEM_RD,  C_ALWAYS, ADD, 5, 1, 0, 0, 0, 3);
      place(OP_PORT_WR, C_ALWAYS, ADD, 5, 5, 0, 0, 0, 0);   // Load used at once
      place(OP_MEM_RD,  C_ALWAYS, ADD, 6, 1, 0, 0, 0, 'h3c);
      place(OP_MEM_RD,  C_ALWAYS, ADD, 7, 1, 0, 0, 0, 'hffff);
      place(OP_PORT_WR, C_ALWAYS, ADD, 6, 6, 0, 0, 0, 0);
      place(OP_PORT_WR, C_ALWAYS, ADD, 7, 7, 0, 0, 0, 0);
      end_program();
      expect_word(5, sext('h7abc));
      expect_word(6, sext('h1357));
      expect_word(7, sext('h9bdf));
      run_and_compare();
      finish_test();
   endtask

   task automatic back_pressure();
      begin_test("back_pressure");
      load_countdown();
      stall_cnt = 0;
      bp_en     = 1'b1;
      run_and_compare();
      bp_en      = 1'b0;
      port_ready = 1'b1;
      if (stall_cnt == 0) begin
         $display("back_pressure: port_ready_i never held a word back");
         errors++;
      end
      finish_test();
   endtask

   task automatic reset_state();
      int n;
      begin_test("reset_state");
      // Port write in writeback while a hazard holds fetch
      new_program();
      place(OP_PORT_WR, C_ALWAYS, ADD, 1, 0, 0, 0, 0, 0);
      place(OP_REG_WR,  C_ALWAYS, ADD, 3, 0, 0, 1, 0, 7);
      place(OP_PORT_WR, C_ALWAYS, ADD, 2, 3, 0, 0, 0, 0);
      end_program();
      reset_core();
      n = 0;
      while (!port_valid && n < PER_TEST_LIMIT) begin
         tick();
         n++;
      end
      if (!port_valid) begin
         $display("reset_state: no port write showed up before the second reset");
         errors++;
      end
      reset_core();
      @(negedge clk_i);
      check_value("port_valid_o", 0, port_valid);
      check_value("pmem_en_o", 1, pmem_en);
      check_value("pmem_addr_o", 0, pmem_addr);
      tick();
      finish_test();
   endtask

   initial begin
      flag       = 1'b0;
      port_ready = 1'b1;
      pmem_dt    = '0;
      rng        = 32'd46;
      tick();
      alu_chain();
      flag_conditions();
      external_flag();
      data_memory();
      back_pressure();
      reset_state();
      $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- tb.f
+incdir+include
src/qcore_pkg.sv
src/qcore_fetch.sv
src/qcore_decode.sv
src/qcore_reg_bank.sv
src/qcore_execute.sv
src/qcore_mem_wb.sv
src/qcore_cpu.sv
sim/tb_qcore.sv

//--- Bender.yml
package:
  name: qcore

export_include_dirs:
  - include

sources:
  - src/qcore_pkg.sv
  - src/qcore_fetch.sv
  - src/qcore_decode.sv
  - src/qcore_reg_bank.sv
  - src/qcore_execute.sv
  - src/qcore_mem_wb.sv
  - src/qcore_cpu.sv
  - target: simulation
    files:
      - sim/tb_qcore.sv
